/* bench/ib_transformer_assert.sv */
/*
 * Handshake assertions for the transformer top level.
 * Outputs idle through reset, and every bus holds its
 * beat steady while stalled.
 */
`timescale 1ns/10ps

module ibTransformerAssert (
  input logic         CLK,
  input logic         rstN,
  input ibPkg::ibWord wideDownData,
  input logic         wideDownSop, wideDownEop, wideDownSrcRdy, wideDownDstRdy,
  input ibPkg::ibByte narrowDownData,
  input logic         narrowDownSop, narrowDownEop, narrowDownSrcRdy, narrowDownDstRdy,
  input ibPkg::ibByte narrowUpData,
  input logic         narrowUpSop, narrowUpEop, narrowUpSrcRdy, narrowUpDstRdy,
  input ibPkg::ibWord wideUpData,
  input logic         wideUpSop, wideUpEop, wideUpSrcRdy, wideUpDstRdy
);

  int failCount = 0;  // read by the testbench

  resetIdle: assert property (@(posedge CLK) !rstN |=> !narrowDownSrcRdy && !wideUpSrcRdy)
    else begin
      failCount++;
      $error("srcRdy high out of reset");
    end

  wideDownHold: assert property (@(posedge CLK) disable iff (!rstN)
    wideDownSrcRdy && !wideDownDstRdy |=> wideDownSrcRdy &&
    $stable(wideDownData) && $stable(wideDownSop) && $stable(wideDownEop))
    else begin
      failCount++;
      $error("wideDown beat changed while stalled");
    end

  narrowDownHold: assert property (@(posedge CLK) disable iff (!rstN)
    narrowDownSrcRdy && !narrowDownDstRdy |=> narrowDownSrcRdy &&
    $stable(narrowDownData) && $stable(narrowDownSop) && $stable(narrowDownEop))
    else begin
      failCount++;
      $error("narrowDown beat changed while stalled");
    end

  narrowUpHold: assert property (@(posedge CLK) disable iff (!rstN)
    narrowUpSrcRdy && !narrowUpDstRdy |=> narrowUpSrcRdy &&
    $stable(narrowUpData) && $stable(narrowUpSop) && $stable(narrowUpEop))
    else begin
      failCount++;
      $error("narrowUp beat changed while stalled");
    end

  wideUpHold: assert property (@(posedge CLK) disable iff (!rstN)
    wideUpSrcRdy && !wideUpDstRdy |=> wideUpSrcRdy &&
    $stable(wideUpData) && $stable(wideUpSop) && $stable(wideUpEop))
    else begin
      failCount++;
      $error("wideUp beat changed while stalled");
    end

endmodule

bind ibTransformer ibTransformerAssert assertU (.*);

/* bench/ib_transformer_tb.sv */
/*
 * Testbench for the internal bus width transformer.
 * Random framed traffic in both directions with random
 * back-pressure; reference models build the expected beats
 * and monitors compare what the DUT delivers.
 */
`timescale 1ns/10ps
`include "ib_defs.svh"

module ibTransformerTb;

  localparam int DOWN_TXNS = 12;  // host to device transactions
  localparam int UP_TXNS   = 12;  // device to host transactions

  logic CLK = 1'b0;
  logic rstN;
  ibPkg::ibWord wideDownData;
  logic wideDownSop, wideDownEop, wideDownSrcRdy, wideDownDstRdy;
  ibPkg::ibByte narrowDownData;
  logic narrowDownSop, narrowDownEop, narrowDownSrcRdy, narrowDownDstRdy;
  ibPkg::ibByte narrowUpData;
  logic narrowUpSop, narrowUpEop, narrowUpSrcRdy, narrowUpDstRdy;
  ibPkg::ibWord wideUpData;
  logic wideUpSop, wideUpEop, wideUpSrcRdy, wideUpDstRdy;

  // stimulus and expected beats
  ibPkg::ibWord wdData[$];
  logic         wdSop[$], wdEop[$];
  ibPkg::ibByte ubData[$];
  logic         ubSop[$], ubEop[$];
  ibPkg::ibByte expB[$];
  logic         expBSop[$], expBEop[$];
  int           expBTxn[$];
  ibPkg::ibWord expW[$];
  logic         expWSop[$], expWEop[$];
  int           expWTxn[$];

  logic [15:0] lfsr;
  int byteErrs, wordErrs, otherErrs;
  int cycles, limit;
  int downStallRun, downStall, upStall;  // back-pressure seen upstream
  int nStall, wStall;                   // remaining forced stall cycles

  ibTransformer i_dut (.*);

  initial begin
    forever #20 CLK = ~CLK;  // 40 ns period
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsrStep()};  // one step per bit
    return v;
  endfunction

  // expected bytes of the wide transaction starting at word `first`
  function automatic void refDown(int first, int txn);
    int rem;
    int idx;
    rem = int'(wdData[first].hdr.len);
    for (int b = 0; b < 8; b++) begin
      expB.push_back(wdData[first].raw[b*8 +: 8]);  // header bytes low first
      expBSop.push_back(b == 0);
      expBEop.push_back(1'b0);
      expBTxn.push_back(txn);
    end
    idx = first;
    while (rem > 0) begin
      idx++;
      for (int b = 0; b < 8 && rem > 0; b++) begin
        expB.push_back(wdData[idx].raw[b*8 +: 8]);
        expBSop.push_back(1'b0);
        expBEop.push_back(1'b0);
        expBTxn.push_back(txn);
        rem--;
      end
    end
    expBEop[expBEop.size()-1] = 1'b1;  // final byte closes it
  endfunction

  // expected words of the byte transaction starting at byte `first`
  function automatic void refUp(int first, int len, int txn);
    ibPkg::ibWord w;
    int pos;
    logic isFirst;
    w.raw = '0;
    pos = 0;
    isFirst = 1'b1;
    for (int i = 0; i < len; i++) begin
      w.raw[pos*8 +: 8] = ubData[first+i];
      pos++;
      if (pos == 8 || i == len - 1) begin  // full word or eop
        expW.push_back(w);
        expWSop.push_back(isFirst);
        expWEop.push_back(i == len - 1);
        expWTxn.push_back(txn);
        isFirst = 1'b0;
        pos = 0;
        w.raw = '0;  // missing high bytes stay zero
      end
    end
  endfunction

  function automatic void genStimulus();
    ibPkg::ibWord w;
    int len, nData, start;
    for (int t = 0; t < DOWN_TXNS; t++) begin
      len = (t == 0) ? 0 : 1 + int'(randBits(6)) % 40;  // txn 0 is header only
      nData = (len + 7) / 8;
      w.hdr.addr = randBits(32);
      w.hdr.reserved = 8'(randBits(8));
      w.hdr.trType = 4'(randBits(4));
      w.hdr.tag = 8'(randBits(8));
      w.hdr.len = `IB_LEN_W'(len);
      start = wdData.size();
      wdData.push_back(w);
      wdSop.push_back(1'b1);
      wdEop.push_back(nData == 0);
      for (int d = 0; d < nData; d++) begin
        w.raw = {randBits(32), randBits(32)};  // unused bytes random too
        wdData.push_back(w);
        wdSop.push_back(1'b0);
        wdEop.push_back(d == nData - 1);
      end
      refDown(start, t);
    end
    for (int t = 0; t < UP_TXNS; t++) begin
      len = 1 + int'(randBits(6)) % 40;
      start = ubData.size();
      for (int i = 0; i < len; i++) begin
        ubData.push_back(8'(randBits(8)));
        ubSop.push_back(i == 0);
        ubEop.push_back(i == len - 1);
      end
      refUp(start, len, t);
    end
  endfunction

  task automatic checkByte(string name, ibPkg::ibByte expData, logic expSop, logic expEop,
                           ibPkg::ibByte actData, logic actSop, logic actEop);
    if ({expData, expSop, expEop} !== {actData, actSop, actEop}) begin
      byteErrs++;
      $display("ERROR %s: expected data %h sop %b eop %b, actual data %h sop %b eop %b",
               name, expData, expSop, expEop, actData, actSop, actEop);
    end
  endtask

  task automatic checkWord(string name, ibPkg::ibWord expData, logic expSop, logic expEop,
                           ibPkg::ibWord actData, logic actSop, logic actEop);
    if ({expData, expSop, expEop} !== {actData, actSop, actEop}) begin
      wordErrs++;
      $display("ERROR %s: expected data %h sop %b eop %b, actual data %h sop %b eop %b",
               name, expData.raw, expSop, expEop, actData.raw, actSop, actEop);
    end
  endtask

  task automatic driveDown();
    for (int i = 0; i < wdData.size(); i++) begin
      @(negedge CLK);
      wideDownData = wdData[i];
      wideDownSop = wdSop[i];
      wideDownEop = wdEop[i];
      wideDownSrcRdy = 1'b1;
      do @(posedge CLK); while (!wideDownDstRdy);  // held until taken
    end
    @(negedge CLK);
    wideDownSrcRdy = 1'b0;
  endtask

  task automatic driveUp();
    for (int i = 0; i < ubData.size(); i++) begin
      @(negedge CLK);
      narrowUpData = ubData[i];
      narrowUpSop = ubSop[i];
      narrowUpEop = ubEop[i];
      narrowUpSrcRdy = 1'b1;
      do @(posedge CLK); while (!narrowUpDstRdy);
    end
    @(negedge CLK);
    narrowUpSrcRdy = 1'b0;
  endtask

  // random sink ready with occasional long stalls
  task automatic driveSinkReady();
    forever begin
      @(negedge CLK);
      if (nStall > 0) nStall--;
      else if (randBits(5) == 0) nStall = 16 + int'(randBits(4));  // fills byte fifo
      if (wStall > 0) wStall--;
      else if (randBits(5) == 0) wStall = 32 + int'(randBits(5));  // fills word fifo
      narrowDownDstRdy = (nStall == 0) && (randBits(2) != 0);
      wideUpDstRdy = (wStall == 0) && (randBits(2) != 0);
    end
  endtask

  // monitors sample at the rising edge where the transfer happens
  always @(posedge CLK) begin
    if (!rstN) begin
      downStallRun = 0;
    end else begin
      if (narrowDownSrcRdy && narrowDownDstRdy) begin
        if (expB.size() == 0) begin
          otherErrs++;
          $display("a byte left narrowDown after all expected bytes were seen");
        end else begin
          checkByte($sformatf("down txn %0d", expBTxn.pop_front()), expB.pop_front(),
                    expBSop.pop_front(), expBEop.pop_front(),
                    narrowDownData, narrowDownSop, narrowDownEop);
        end
      end
      if (wideUpSrcRdy && wideUpDstRdy) begin
        if (expW.size() == 0) begin
          otherErrs++;
          $display("a word left wideUp after all expected words were seen");
        end else begin
          checkWord($sformatf("up txn %0d", expWTxn.pop_front()), expW.pop_front(),
                    expWSop.pop_front(), expWEop.pop_front(),
                    wideUpData, wideUpSop, wideUpEop);
        end
      end
      // longer than one held word means the byte fifo is full
      downStallRun = (wideDownSrcRdy && !wideDownDstRdy) ? downStallRun + 1 : 0;
      if (downStallRun > 9) downStall++;
      if (narrowUpSrcRdy && !narrowUpDstRdy) upStall++;
    end
  end

  // run limit from the stimulus size
  initial begin
    do begin
      @(posedge CLK);
      cycles++;
    end while (limit == 0 || cycles <= limit);
    $display("timeout after %0d cycles, expected beats still missing", cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    wideDownData = '0;
    wideDownSop = 1'b0;
    wideDownEop = 1'b0;
    wideDownSrcRdy = 1'b0;
    narrowDownDstRdy = 1'b1;
    narrowUpData = '0;
    narrowUpSop = 1'b0;
    narrowUpEop = 1'b0;
    narrowUpSrcRdy = 1'b0;
    wideUpDstRdy = 1'b1;
    {byteErrs, wordErrs, otherErrs, cycles, limit} = '0;
    {downStall, upStall, nStall, wStall} = '0;
    lfsr = 16'd37357;
    genStimulus();
    limit = 4 * (wdData.size() + expB.size() + ubData.size() + expW.size()) + 1000;
    repeat (8) @(negedge CLK);
    rstN = 1'b1;
    if (narrowDownSrcRdy || wideUpSrcRdy || !wideDownDstRdy || !narrowUpDstRdy) begin
      otherErrs++;
      $display("ready signals wrong right after reset");
    end
    fork
      driveSinkReady();
    join_none
    fork
      driveDown();
      driveUp();
    join
    while (expB.size() != 0 || expW.size() != 0) @(posedge CLK);
    repeat (20) @(negedge CLK);  // catch extra beats
    if (downStall == 0) begin
      otherErrs++;
      $display("wideDownDstRdy never stayed low for a full byte fifo");
    end
    if (upStall == 0) begin
      otherErrs++;
      $display("narrowUpDstRdy never went low under upward back-pressure");
    end
    $display("errors: byte %0d word %0d other %0d assertion %0d",
             byteErrs, wordErrs, otherErrs, i_dut.assertU.failCount);
    if (byteErrs + wordErrs + otherErrs + i_dut.assertU.failCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* design/ib_defs.svh */
/*
 * Internal bus width transformer, shared definitions.
 * Bus widths, header field widths and buffer depths
 * for the 64-bit host side and the 8-bit device side.
 */
`ifndef IB_DEFS_SVH
`define IB_DEFS_SVH

// data widths of the two sides
`define IB_WIDE_W    64  // host side word
`define IB_NARROW_W  8   // device side byte

// header fields, msb first, sum must be IB_WIDE_W
`define IB_ADDR_W    32  // target address
`define IB_RSVD_W    8   // unused, carried through
`define IB_TYPE_W    4   // transaction type, passed through
`define IB_TAG_W     8   // transaction tag
`define IB_LEN_W     12  // payload bytes after the header

// buffer depths
`define IB_DOWN_DEPTH  16  // byte fifo on the downward path
`define IB_UP_DEPTH    4   // word fifo on the upward path

// flag bits carried alongside data inside a fifo word
`define IB_FLAG_W    2   // sop and eop

`endif

/* design/ib_deserializer.sv */
/*
 * Upward deserializer.
 * Packs framed device bytes into host words in arrival order.
 * A word is complete at byte 7 or at eop; bytes not received
 * stay zero. The byte side stalls while a finished word waits.
 */
`timescale 1ns/10ps
`include "ib_defs.svh"

module ibDeserializer (
  input  logic          CLK,
  input  logic          rstN,
  input  ibPkg::ibByte  narrowData,
  input  logic          narrowSop,
  input  logic          narrowEop,
  input  logic          narrowSrcRdy,
  output logic          narrowDstRdy,
  output ibPkg::ibWord  wrData,
  output logic          wrSop,
  output logic          wrEop,
  output logic          wrSrcRdy,
  input  logic          wrDstRdy
);

  xferPkg::byteIdxT byteIdx;   // next free position
  xferPkg::byteIdxT pos;       // position of the incoming byte
  ibPkg::ibWord     wordReg;   // word under construction
  logic             wordSop;   // first word of its transaction
  logic             wordEop;   // word holds the eop byte
  logic             full;      // completed word waiting for the fifo
  logic             byteTake;
  logic             wordTake;
  logic             complete;  // incoming byte closes the word

  assign pos      = narrowSop ? '0 : byteIdx;  // sop always restarts at 0
  assign complete = narrowEop || (pos == xferPkg::LAST_IDX);

  assign wrSrcRdy     = full;
  assign wrData       = wordReg;
  assign wrSop        = wordSop;
  assign wrEop        = wordEop;
  assign narrowDstRdy = !full || wrDstRdy;  // held word leaves this edge

  assign byteTake = narrowSrcRdy && narrowDstRdy;
  assign wordTake = wrSrcRdy && wrDstRdy;

  // control
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      full    <= 1'b0;
      byteIdx <= '0;
    end else begin
      if (wordTake) begin
        full <= 1'b0;
      end
      if (byteTake) begin
        byteIdx <= complete ? '0 : pos + xferPkg::byteIdxT'(1);
        if (complete) begin
          full <= 1'b1;  // hold until the fifo takes it
        end
      end
    end
  end

  // word assembly
  always_ff @(posedge CLK) begin
    if (byteTake) begin
      if (pos == '0) begin
        wordReg.raw <= {{(`IB_WIDE_W - `IB_NARROW_W){1'b0}}, narrowData};  // zero-fill
        wordSop     <= narrowSop;
      end else begin
        wordReg.raw[{pos, 3'b000} +: `IB_NARROW_W] <= narrowData;
      end
      wordEop <= narrowEop;  // last value before completion counts
    end
  end

endmodule

/* design/ib_fifo.sv */
/*
 * First-word-fall-through FIFO with ready/ready ports.
 * Circular buffer with read and write pointers and an
 * occupancy count. Head entry is visible on rdData as soon
 * as the FIFO is not empty.
 */
`timescale 1ns/10ps

module ibFifo #(
  parameter int WIDTH = 10,
  parameter int DEPTH = 16
) (
  input  logic             CLK,
  input  logic             rstN,
  input  logic [WIDTH-1:0] wrData,
  input  logic             wrSrcRdy,
  output logic             wrDstRdy,
  output logic [WIDTH-1:0] rdData,
  output logic             rdSrcRdy,
  input  logic             rdDstRdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];  // storage
  logic [PTR_W-1:0] wrPtr;        // next free slot
  logic [PTR_W-1:0] rdPtr;        // head slot
  logic [CNT_W-1:0] count;        // entries held
  logic             doWr;
  logic             doRd;
  logic             full;

  assign full     = (count == CNT_W'(DEPTH));
  assign rdSrcRdy = (count != '0);
  assign wrDstRdy = !full || rdDstRdy;  // full but draining this edge
  assign rdData   = mem[rdPtr];           // fall-through head

  assign doWr = wrSrcRdy && wrDstRdy;
  assign doRd = rdSrcRdy && rdDstRdy;

  always_ff @(posedge CLK) begin
    if (doWr) begin
      mem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWr) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + PTR_W'(1);  // wrap
      end
      if (doRd) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + PTR_W'(1);
      end
      case ({doWr, doRd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // none, or both at once
      endcase
    end
  end

endmodule

/* design/ib_pkg.sv */
/*
 * Internal bus formats.
 * Header layout of the first word of a transaction, the host
 * word seen either as raw data or as a header, and the byte
 * type of the device side.
 */
`include "ib_defs.svh"

package ibPkg;

  // first word of a downward transaction
  typedef struct packed {
    logic [`IB_ADDR_W-1:0] addr;      // bits 63:32
    logic [`IB_RSVD_W-1:0] reserved;  // bits 31:24
    logic [`IB_TYPE_W-1:0] trType;    // bits 23:20
    logic [`IB_TAG_W-1:0]  tag;       // bits 19:12
    logic [`IB_LEN_W-1:0]  len;       // bits 11:0, payload byte count
  } ibHeader;

  // one host word, decoded as header on sop and as data otherwise
  typedef union packed {
    logic [`IB_WIDE_W-1:0] raw;  // byte 0 in bits 7:0
    ibHeader               hdr;  // header view of the same bits
  } ibWord;

  // device side data
  typedef logic [`IB_NARROW_W-1:0] ibByte;

endpackage

/* design/ib_serializer.sv */
/*
 * Downward serializer.
 * Takes framed host words and hands them to the byte fifo one
 * byte per cycle, low byte first. The header length trims the
 * unused bytes of the word that carries eop.
 */
`timescale 1ns/10ps
`include "ib_defs.svh"

module ibSerializer (
  input  logic          CLK,
  input  logic          rstN,
  input  ibPkg::ibWord  wideData,
  input  logic          wideSop,
  input  logic          wideEop,
  input  logic          wideSrcRdy,
  output logic          wideDstRdy,
  output ibPkg::ibByte  wrData,
  output logic          wrSop,
  output logic          wrEop,
  output logic          wrSrcRdy,
  input  logic          wrDstRdy
);

  xferPkg::serStateT     state;      // what the held word is
  xferPkg::byteIdxT      byteIdx;    // next byte of the held word
  ibPkg::ibWord          wordReg;    // held host word
  logic                  wordEop;    // held word closes the transaction
  logic [`IB_LEN_W-1:0]  remaining;  // payload bytes still owed
  logic                  lastByte;   // current byte ends the held word
  logic                  byteDone;   // byte goes into the fifo this cycle
  logic                  wordDone;   // held word fully written
  logic                  wideTake;   // host word accepted this cycle

  // end of word: header always 8 bytes, data trimmed only on eop word
  always_comb begin
    case (state)
      xferPkg::SER_HEADER: lastByte = (byteIdx == xferPkg::LAST_IDX);
      xferPkg::SER_DATA:   lastByte = (byteIdx == xferPkg::LAST_IDX) ||
                                      (wordEop && remaining == `IB_LEN_W'(1));
      default:             lastByte = 1'b0;
    endcase
  end

  assign wrSrcRdy = (state != xferPkg::SER_IDLE);  // a word is held
  assign wrData   = wordReg.raw[{byteIdx, 3'b000} +: `IB_NARROW_W];  // byte select
  assign wrSop    = (state == xferPkg::SER_HEADER) && (byteIdx == '0);
  assign wrEop    = wordEop && lastByte;  // final wanted byte of the transaction

  assign byteDone   = wrSrcRdy && wrDstRdy;
  assign wordDone   = byteDone && lastByte;
  assign wideDstRdy = (state == xferPkg::SER_IDLE) || wordDone;  // free now or freed this edge
  assign wideTake   = wideSrcRdy && wideDstRdy;

  // control
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state   <= xferPkg::SER_IDLE;
      byteIdx <= '0;
      wordEop <= 1'b0;
    end else begin
      if (byteDone) begin
        byteIdx <= byteIdx + xferPkg::byteIdxT'(1);  // step to next byte
      end
      if (wordDone) begin
        state <= xferPkg::SER_IDLE;  // unless refilled below
      end
      if (wideTake) begin
        byteIdx <= '0;  // restart at byte 0
        wordEop <= wideEop;
        state   <= wideSop ? xferPkg::SER_HEADER : xferPkg::SER_DATA;
      end
    end
  end

  // held word and payload count
  always_ff @(posedge CLK) begin
    if (byteDone && state == xferPkg::SER_DATA) begin
      remaining <= remaining - `IB_LEN_W'(1);  // one payload byte gone
    end
    if (wideTake) begin
      wordReg <= wideData;
      if (wideSop) begin
        remaining <= wideData.hdr.len;  // header view of the sop word
      end
    end
  end

endmodule

/* design/ib_transformer.sv */
/*
 * Internal bus width transformer, top level.
 * Downward: serializer into a byte FIFO toward the device.
 * Upward: deserializer into a word FIFO toward the host.
 * Sop and eop ride in the FIFO words above the data bits.
 */
`timescale 1ns/10ps
`include "ib_defs.svh"

module ibTransformer (
  input  logic          CLK,
  input  logic          rstN,
  // host to transformer
  input  ibPkg::ibWord  wideDownData,
  input  logic          wideDownSop,
  input  logic          wideDownEop,
  input  logic          wideDownSrcRdy,
  output logic          wideDownDstRdy,
  // transformer to device
  output ibPkg::ibByte  narrowDownData,
  output logic          narrowDownSop,
  output logic          narrowDownEop,
  output logic          narrowDownSrcRdy,
  input  logic          narrowDownDstRdy,
  // device to transformer
  input  ibPkg::ibByte  narrowUpData,
  input  logic          narrowUpSop,
  input  logic          narrowUpEop,
  input  logic          narrowUpSrcRdy,
  output logic          narrowUpDstRdy,
  // transformer to host
  output ibPkg::ibWord  wideUpData,
  output logic          wideUpSop,
  output logic          wideUpEop,
  output logic          wideUpSrcRdy,
  input  logic          wideUpDstRdy
);

  localparam int DOWN_W = `IB_NARROW_W + `IB_FLAG_W;  // eop, sop, byte
  localparam int UP_W   = `IB_WIDE_W + `IB_FLAG_W;    // eop, sop, word

  ibPkg::ibByte      serData;
  logic              serSop, serEop, serSrcRdy, serDstRdy;
  ibPkg::ibWord      desData;
  logic              desSop, desEop, desSrcRdy, desDstRdy;
  logic [DOWN_W-1:0] downRdData;
  logic [UP_W-1:0]   upRdData;

  ibSerializer serU (
    .CLK        (CLK),
    .rstN       (rstN),
    .wideData   (wideDownData),
    .wideSop    (wideDownSop),
    .wideEop    (wideDownEop),
    .wideSrcRdy (wideDownSrcRdy),
    .wideDstRdy (wideDownDstRdy),
    .wrData     (serData),
    .wrSop      (serSop),
    .wrEop      (serEop),
    .wrSrcRdy   (serSrcRdy),
    .wrDstRdy   (serDstRdy)
  );

  ibFifo #(.WIDTH(DOWN_W), .DEPTH(`IB_DOWN_DEPTH)) downFifoU (
    .CLK      (CLK),
    .rstN     (rstN),
    .wrData   ({serEop, serSop, serData}),
    .wrSrcRdy (serSrcRdy),
    .wrDstRdy (serDstRdy),
    .rdData   (downRdData),
    .rdSrcRdy (narrowDownSrcRdy),
    .rdDstRdy (narrowDownDstRdy)
  );

  assign narrowDownData = downRdData[`IB_NARROW_W-1:0];
  assign narrowDownSop  = downRdData[`IB_NARROW_W];
  assign narrowDownEop  = downRdData[`IB_NARROW_W+1];

  ibDeserializer desU (
    .CLK          (CLK),
    .rstN         (rstN),
    .narrowData   (narrowUpData),
    .narrowSop    (narrowUpSop),
    .narrowEop    (narrowUpEop),
    .narrowSrcRdy (narrowUpSrcRdy),
    .narrowDstRdy (narrowUpDstRdy),
    .wrData       (desData),
    .wrSop        (desSop),
    .wrEop        (desEop),
    .wrSrcRdy     (desSrcRdy),
    .wrDstRdy     (desDstRdy)
  );

  ibFifo #(.WIDTH(UP_W), .DEPTH(`IB_UP_DEPTH)) upFifoU (
    .CLK      (CLK),
    .rstN     (rstN),
    .wrData   ({desEop, desSop, desData}),
    .wrSrcRdy (desSrcRdy),
    .wrDstRdy (desDstRdy),
    .rdData   (upRdData),
    .rdSrcRdy (wideUpSrcRdy),
    .rdDstRdy (wideUpDstRdy)
  );

  assign wideUpData = upRdData[`IB_WIDE_W-1:0];
  assign wideUpSop  = upRdData[`IB_WIDE_W];
  assign wideUpEop  = upRdData[`IB_WIDE_W+1];

endmodule

/* design/xfer_pkg.sv */
/*
 * Transformer control types.
 * Serializer sequencing states and the byte position
 * used by both the serializer and the deserializer.
 */
`include "ib_defs.svh"

package xferPkg;

  typedef enum logic [1:0] {
    SER_IDLE,    // no word held
    SER_HEADER,  // emitting the 8 header bytes
    SER_DATA     // emitting payload bytes
  } serStateT;

  // byte position inside a host word
  typedef logic [2:0] byteIdxT;

  // position of the last byte of a word
  localparam byteIdxT LAST_IDX = byteIdxT'(`IB_WIDE_W / `IB_NARROW_W - 1);

endpackage

/* run.sh */
#!/bin/sh
# Build and run the transformer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module ibTransformerTb \
  -o simTb

# the log decides pass or fail
./obj_dir/simTb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  exit 1
fi

/* sources.f */
+incdir+design
design/ib_pkg.sv
design/xfer_pkg.sv
design/ib_serializer.sv
design/ib_fifo.sv
design/ib_deserializer.sv
design/ib_transformer.sv
bench/ib_transformer_assert.sv
bench/ib_transformer_tb.sv
